//--- hdl/bpuPkg.sv
package bpuPkg;

    // predictor sizes
    localparam int HIST_BITS = 6;
    localparam int BHT_BITS  = 10;
    // history table index starts above the word offset
    localparam int PC_LO     = 2;

    // MIPS32 opcode fields used by the branch decoder
    localparam logic [5:0] OP_REGIMM    = 6'b000001;
    // beq, bne, blez, bgtz share the upper opcode bits
    localparam logic [3:0] OP_BRANCH_HI = 4'b0001;
    // regimm subcode bits 19..17 for bltz/bgez/bltzal/bgezal
    localparam logic [2:0] REGIMM_BR_LO = 3'b000;
    // likely variants of the same group
    localparam logic [2:0] REGIMM_BR_HI = 3'b001;

    // gray-ordered saturating counter, upper bit is the guess
    typedef enum logic [1:0] {
        StrongNot   = 2'b00,
        WeakNot     = 2'b01,
        WeakTaken   = 2'b11,
        StrongTaken = 2'b10
    } ctrState;

    // one instruction word, rt field read as register or regimm subcode
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iForm;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  subcode;
            logic [15:0] imm;
        } regimmForm;
    } instrWord;

endpackage

//--- hdl/historyIf.sv
`timescale 1ns/1ps

interface historyIf;
    import bpuPkg::*;

    // history of the fetch PC, used as pattern table read index
    logic [HIST_BITS-1:0] fetchHist;
    // history of the resolving PC before its shift
    logic [HIST_BITS-1:0] trainHist;
    // one-cycle strobe, same cycle as branchE
    logic                 trainValid;
    logic                 trainTaken;

    modport histTable (
        output fetchHist,
        output trainHist,
        output trainValid,
        output trainTaken
    );

    modport counters (
        input fetchHist,
        input trainHist,
        input trainValid,
        input trainTaken
    );

endinterface

//--- hdl/branchDecoder.sv
`timescale 1ns/1ps

module branchDecoder (
    input  logic [31:0] instrD,
    output logic        branchD
);
    import bpuPkg::*;

    instrWord word;
    logic     isCondOp;
    logic     isRegimm;
    logic     isRegimmBranch;

    assign word = instrD;

    // beq, bne, blez, bgtz
    assign isCondOp = (word.iForm.opcode[5:2] == OP_BRANCH_HI);

    assign isRegimm = (word.regimmForm.opcode == OP_REGIMM);

    // rt slot holds a subcode here, bit 20 only picks the linking flavour
    always_comb begin
        isRegimmBranch = 1'b0;
        if (isRegimm) begin
            case (word.regimmForm.subcode[3:1])
                REGIMM_BR_LO: isRegimmBranch = 1'b1;
                REGIMM_BR_HI: isRegimmBranch = 1'b1;
                default:      isRegimmBranch = 1'b0;
            endcase
        end
    end

    assign branchD = isCondOp | isRegimmBranch;

    // a known word must always classify
    always_comb begin
        assert ($isunknown(instrD) || !$isunknown(branchD))
            else $error("branchD unknown for a known instruction word");
    end

endmodule

//--- hdl/localHistoryTable.sv
`timescale 1ns/1ps

module localHistoryTable (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pcF,
    input  logic [31:0] pcE,
    input  logic        branchE,
    input  logic        takenE,
    historyIf.histTable hist
);
    import bpuPkg::*;

    localparam int ENTRIES = 1 << BHT_BITS;

    // one shift register of outcomes per PC slot
    logic [HIST_BITS-1:0] histMem [ENTRIES];

    logic [BHT_BITS-1:0]  fetchIdx;
    logic [BHT_BITS-1:0]  trainIdx;
    logic [HIST_BITS-1:0] trainOld;

    // word-aligned PC slice, aliasing above bit 11 is accepted
    assign fetchIdx = pcF[PC_LO +: BHT_BITS];
    assign trainIdx = pcE[PC_LO +: BHT_BITS];

    // read before write, both lookups see the old contents
    assign trainOld = histMem[trainIdx];

    assign hist.fetchHist  = histMem[fetchIdx];
    assign hist.trainHist  = trainOld;
    assign hist.trainValid = branchE;
    assign hist.trainTaken = takenE;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                histMem[i] <= '0;
            end
        end else if (branchE) begin
            // newest outcome enters at bit 0
            histMem[trainIdx] <= {trainOld[HIST_BITS-2:0], takenE};
        end
    end

endmodule

//--- hdl/patternTable.sv
`timescale 1ns/1ps

module patternTable (
    input  logic       clk,
    input  logic       rst,
    historyIf.counters hist,
    output logic       predTakeF
);
    import bpuPkg::*;

    localparam int ENTRIES = 1 << HIST_BITS;

    ctrState ctrMem [ENTRIES];
    ctrState fetchCtr;
    ctrState trainCtr;
    ctrState nextCtr;

    assign fetchCtr = ctrMem[hist.fetchHist];
    assign trainCtr = ctrMem[hist.trainHist];

    // upper counter bit is the guess
    assign predTakeF = fetchCtr[1];

    // one step along the chain, saturating at both ends
    always_comb begin
        case (trainCtr)
            StrongNot:   nextCtr = hist.trainTaken ? WeakNot     : StrongNot;
            WeakNot:     nextCtr = hist.trainTaken ? WeakTaken   : StrongNot;
            WeakTaken:   nextCtr = hist.trainTaken ? StrongTaken : WeakNot;
            StrongTaken: nextCtr = hist.trainTaken ? StrongTaken : WeakTaken;
            default:     nextCtr = StrongNot;
        endcase
    end

    // counters only move when a branch resolves
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctrMem[i] <= StrongNot;
            end
        end else if (hist.trainValid) begin
            ctrMem[hist.trainHist] <= nextCtr;
        end
    end

    // trained entry stays known and at most one gray step away
    assert property (
        @(posedge clk) disable iff (rst)
        hist.trainValid |=>
            !$isunknown(ctrMem[$past(hist.trainHist)]) &&
            ($countones(ctrMem[$past(hist.trainHist)] ^ $past(trainCtr)) <= 1)
    ) else $error("pattern counter left the legal chain");

endmodule

//--- hdl/predictStage.sv
`timescale 1ns/1ps

module predictStage (
    input  logic clk,
    input  logic rst,
    input  logic flushD,
    input  logic stallD,
    input  logic predTakeF,
    input  logic branchD,
    output logic predTakeD
);

    // fetch guess as seen by decode
    logic guessD;

    // flush beats stall
    always_ff @(posedge clk) begin
        if (rst || flushD) begin
            guessD <= 1'b0;
        end else if (!stallD) begin
            guessD <= predTakeF;
        end
    end

    // only branches report a guess
    assign predTakeD = guessD & branchD;

    // a taken guess came from fetch one edge back, or was held there by a stall
    assert property (
        @(posedge clk) disable iff (rst)
        predTakeD |-> branchD && !$past(flushD) && ($past(predTakeF) || $past(stallD))
    ) else $error("taken guess in decode not traceable to fetch or stall");

endmodule

//--- hdl/branchPredictUnit.sv
`timescale 1ns/1ps

module branchPredictUnit (
    input  logic        clk,
    input  logic        rst,

    // decode stage control
    input  logic        flushD,
    input  logic        stallD,
    input  logic [31:0] instrD,

    // fetch lookup
    input  logic [31:0] pcF,

    // execute resolve
    input  logic [31:0] pcE,
    input  logic        branchE,
    input  logic        takenE,

    output logic        branchD,
    output logic        predTakeD
);

    logic predTakeF;

    // histories from the local table into the counters
    historyIf histBus ();

    branchDecoder decoder (
        .instrD  (instrD),
        .branchD (branchD)
    );

    localHistoryTable historyTable (
        .clk     (clk),
        .rst     (rst),
        .pcF     (pcF),
        .pcE     (pcE),
        .branchE (branchE),
        .takenE  (takenE),
        .hist    (histBus.histTable)
    );

    patternTable counters (
        .clk       (clk),
        .rst       (rst),
        .hist      (histBus.counters),
        .predTakeF (predTakeF)
    );

    predictStage stageD (
        .clk       (clk),
        .rst       (rst),
        .flushD    (flushD),
        .stallD    (stallD),
        .predTakeF (predTakeF),
        .branchD   (branchD),
        .predTakeD (predTakeD)
    );

endmodule

//--- testbench/bpuTb.sv
`timescale 1ns/1ps

module bpuTb;
    import bpuPkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    localparam logic [31:0] LFSR_SEED   = 32'h3d32_adee;
    localparam logic [31:0] GALOIS_TAPS = 32'hd000_0001;

    // cycle budget per test, summed for the watchdog
    localparam int DECODE_CYCLES  = 200;
    localparam int SCAN_CYCLES    = 1 << BHT_BITS;
    localparam int TRAIN_CYCLES   = 20;
    localparam int PATTERN_CYCLES = 96;
    localparam int PIPE_CYCLES    = 17;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int MARGIN_CYCLES  = 200;
    localparam int TOTAL_CYCLES   = 2 * (RESET_CYCLES + 1) + DECODE_CYCLES + SCAN_CYCLES
                                  + TRAIN_CYCLES + PATTERN_CYCLES + PIPE_CYCLES + RANDOM_CYCLES;
    localparam int WATCHDOG_NS    = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam logic [31:0] BEQ_WORD = 32'h1085_fffc;
    localparam logic [31:0] BNE_WORD = 32'h1485_0010;

    localparam logic [31:0] PC_A = 32'h0040_0100;
    localparam logic [31:0] PC_B = 32'h0040_0204;
    localparam logic [31:0] PC_C = 32'h0040_0308;
    localparam logic [31:0] PC_D = 32'h0040_040c;
    // last one aliases PC_A in the history table
    localparam logic [31:0] TRAIN_PCS [4] = '{PC_A, PC_B, PC_C, 32'h0040_1100};

    logic        clk = 1'b0;
    logic        rst;
    logic        flushD;
    logic        stallD;
    logic [31:0] instrD;
    logic [31:0] pcF;
    logic [31:0] pcE;
    logic        branchE;
    logic        takenE;
    logic        branchD;
    logic        predTakeD;

    logic [31:0] lfsrState;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount  = 0;
    logic        lastPredTakeD;

    // reference state, counters kept as levels 0 (strong not) to 3 (strong taken)
    logic [HIST_BITS-1:0] modelHist [1 << BHT_BITS];
    int                   modelCtr  [1 << HIST_BITS];
    logic                 modelGuess;

    branchPredictUnit i_dut (
        .clk       (clk),
        .rst       (rst),
        .flushD    (flushD),
        .stallD    (stallD),
        .instrD    (instrD),
        .pcF       (pcF),
        .pcE       (pcE),
        .branchE   (branchE),
        .takenE    (takenE),
        .branchD   (branchD),
        .predTakeD (predTakeD)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at time %0t before all tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

    // one LFSR step per returned bit
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ GALOIS_TAPS;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
        return value;
    endfunction

    // half of the words land on regimm or the beq group
    function automatic logic [31:0] randomInstr();
        logic [31:0] kind;
        logic [31:0] word;
        kind = randBits(2);
        word = randBits(32);
        if (kind == 0) begin
            word[31:26] = OP_REGIMM;
        end else if (kind == 1) begin
            word[31:28] = OP_BRANCH_HI;
        end
        return word;
    endfunction

    function automatic logic expectBranch(input logic [31:0] raw);
        instrWord w;
        w = raw;
        if (w.iForm.opcode[5:2] == OP_BRANCH_HI) begin
            return 1'b1;
        end
        if (w.regimmForm.opcode == OP_REGIMM &&
            (w.regimmForm.subcode[3:1] == REGIMM_BR_LO ||
             w.regimmForm.subcode[3:1] == REGIMM_BR_HI)) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic checkValue(input string what, input logic got, input logic expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("test %s finished with %0d mismatches", name, errorCount - startErrors);
    endtask

    task automatic resetModel();
        for (int i = 0; i < (1 << BHT_BITS); i++) begin
            modelHist[i] = '0;
        end
        for (int i = 0; i < (1 << HIST_BITS); i++) begin
            modelCtr[i] = 0;
        end
        modelGuess = 1'b0;
    endtask

    // what the coming rising edge does, tables read before they are written
    task automatic advanceModel();
        logic [BHT_BITS-1:0]  fetchIdx;
        logic [BHT_BITS-1:0]  trainIdx;
        logic [HIST_BITS-1:0] oldHist;
        logic                 fetchGuess;
        fetchIdx   = pcF[PC_LO +: BHT_BITS];
        fetchGuess = (modelCtr[modelHist[fetchIdx]] >= 2);
        if (flushD) begin
            modelGuess = 1'b0;
        end else if (!stallD) begin
            modelGuess = fetchGuess;
        end
        if (branchE) begin
            trainIdx = pcE[PC_LO +: BHT_BITS];
            oldHist  = modelHist[trainIdx];
            if (takenE && modelCtr[oldHist] < 3) begin
                modelCtr[oldHist]++;
            end else if (!takenE && modelCtr[oldHist] > 0) begin
                modelCtr[oldHist]--;
            end
            modelHist[trainIdx] = {oldHist[HIST_BITS-2:0], takenE};
        end
    endtask

    // entered on a falling edge with inputs set, returns on the next one
    task automatic runCycle();
        logic expBranch;
        #1;
        expBranch     = expectBranch(instrD);
        lastPredTakeD = predTakeD;
        checkValue("branchD", branchD, expBranch);
        checkValue("predTakeD", predTakeD, modelGuess & expBranch);
        advanceModel();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        resetModel();
    endtask

    task automatic testDecode();
        int startErrors;
        startErrors = errorCount;
        branchE = 1'b0;
        for (int i = 0; i < DECODE_CYCLES; i++) begin
            instrD = randomInstr();
            pcF    = randBits(32);
            runCycle();
        end
        reportTest("decode", startErrors);
    endtask

    // runs after training so the reset has trained entries to clear
    task automatic testResetState();
        int startErrors;
        startErrors = errorCount;
        applyReset();
        instrD = BEQ_WORD;
        for (int i = 0; i < SCAN_CYCLES; i++) begin
            pcF = 32'h0040_0000 | (i << PC_LO);
            runCycle();
            checkValue("guess after reset", lastPredTakeD, 1'b0);
        end
        reportTest("reset state", startErrors);
    endtask

    task automatic testCounterTraining();
        int startErrors;
        startErrors = errorCount;
        instrD  = BEQ_WORD;
        pcF     = PC_A;
        pcE     = PC_A;
        branchE = 1'b1;
        takenE  = 1'b1;
        repeat (8) runCycle();
        branchE = 1'b0;
        repeat (2) runCycle();
        checkValue("guess after taken run", lastPredTakeD, 1'b1);
        branchE = 1'b1;
        takenE  = 1'b0;
        repeat (8) runCycle();
        branchE = 1'b0;
        repeat (2) runCycle();
        checkValue("guess after not-taken run", lastPredTakeD, 1'b0);
        reportTest("counter training", startErrors);
    endtask

    // PC_B alternates, PC_C repeats taken taken not-taken
    task automatic testLocalPatterns();
        int startErrors;
        int stepB;
        int stepC;
        startErrors = errorCount;
        stepB   = 0;
        stepC   = 0;
        instrD  = BNE_WORD;
        branchE = 1'b1;
        for (int i = 0; i < PATTERN_CYCLES; i++) begin
            if (i % 2 == 0) begin
                pcE    = PC_B;
                takenE = (stepB % 2 == 0);
                stepB++;
            end else begin
                pcE    = PC_C;
                takenE = (stepC % 3 != 2);
                stepC++;
            end
            pcF = (randBits(1) == 1) ? PC_B : PC_C;
            runCycle();
        end
        branchE = 1'b0;
        reportTest("local history patterns", startErrors);
    endtask

    task automatic testPipelineControl();
        int startErrors;
        startErrors = errorCount;
        instrD  = BEQ_WORD;
        pcF     = PC_D;
        pcE     = PC_D;
        branchE = 1'b1;
        takenE  = 1'b1;
        repeat (10) runCycle();
        branchE = 1'b0;
        runCycle();
        stallD = 1'b1;
        pcF    = randBits(32);
        runCycle();
        checkValue("taken before stall", lastPredTakeD, 1'b1);
        repeat (3) begin
            pcF = randBits(32);
            runCycle();
            checkValue("held under stall", lastPredTakeD, 1'b1);
        end
        // flush and stall together
        flushD = 1'b1;
        runCycle();
        flushD = 1'b0;
        runCycle();
        checkValue("cleared by flush over stall", lastPredTakeD, 1'b0);
        stallD = 1'b0;
        reportTest("pipeline control", startErrors);
    endtask

    task automatic testRandomMix();
        int          startErrors;
        logic [31:0] pick;
        startErrors = errorCount;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pick    = randBits(2);
            pcE     = TRAIN_PCS[pick[1:0]];
            pick    = randBits(2);
            pcF     = (randBits(2) == 0) ? randBits(32) : TRAIN_PCS[pick[1:0]];
            branchE = (randBits(1) == 1);
            takenE  = (randBits(1) == 1);
            stallD  = (randBits(3) == 0);
            flushD  = (randBits(4) == 0);
            instrD  = randomInstr();
            runCycle();
        end
        stallD  = 1'b0;
        flushD  = 1'b0;
        branchE = 1'b0;
        reportTest("random mix", startErrors);
    endtask

    initial begin
        lfsrState = LFSR_SEED;
        rst       = 1'b1;
        flushD    = 1'b0;
        stallD    = 1'b0;
        instrD    = '0;
        pcF       = '0;
        pcE       = '0;
        branchE   = 1'b0;
        takenE    = 1'b0;
        applyReset();

        testDecode();
        testCounterTraining();
        testLocalPatterns();
        testPipelineControl();
        testResetState();
        testRandomMix();

        $display("%0d tests run, %0d checks, %0d mismatches", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
hdl/bpuPkg.sv
hdl/historyIf.sv
hdl/branchDecoder.sv
hdl/localHistoryTable.sv
hdl/patternTable.sv
hdl/predictStage.sv
hdl/branchPredictUnit.sv
testbench/bpuTb.sv

//--- run.sh
#!/bin/sh
# builds the branch predictor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module bpuTb -f sources.f \
    --Mdir obj_dir -o bpuSim \
    && ./obj_dir/bpuSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "run.sh: build or simulation error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log \
    && { echo "run.sh: testbench reported failure"; exit 1; } \
    || { echo "run.sh: no failure found in sim.log"; exit 0; }
